/* verilog/rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register slots
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] reg_idx_t; // 0 = command read, 1..9 = time and timer bytes

  localparam int NUM_REGS = 9;

  localparam logic [7:0] CMD_ADDR = 8'hF0; // reading it latches the chip counters

  // sec, min, hour, day, month, year, tmr sec, tmr min, tmr hour
  localparam logic [7:0] REG_ADDR [1:NUM_REGS] = '{
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h31, 8'h32, 8'h33
  };

  // sequencer codes outside the 0..9 read range
  localparam reg_idx_t SEQ_FIN  = 4'd10;
  localparam reg_idx_t SEQ_IDLE = 4'd15;

  ////////////////////////////////////////////////////////////////////////////
  // chip bus timing
  ////////////////////////////////////////////////////////////////////////////

  localparam int ALE_CYCLES = 2; // address held with ale high
  localparam int RD_CYCLES  = 3; // rd_n low, byte taken in the last one

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_ADDR = 2'd1;
  localparam logic [1:0] PH_READ = 2'd2;

endpackage

`default_nettype wire

/* verilog/rtc_bus_port.sv */
`default_nettype none

// one read cycle on the muxed address/data bus of the clock chip
module rtc_bus_port (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        abort,
  input  wire        rd_req,
  input  wire  [7:0] rd_addr,
  output logic [7:0] rd_data,
  output logic       done,
  output logic       rtc_cs_n,
  output logic       rtc_ale,
  output logic       rtc_rd_n,
  output logic [7:0] rtc_ad_out,
  output logic       rtc_ad_oe,
  input  wire  [7:0] rtc_ad_in
);

  logic [1:0] phase;
  logic [1:0] cnt;       // cycles spent in the current phase
  logic       addr_last;
  logic       read_last;

  assign addr_last = (int'(cnt) == rtc_pkg::ALE_CYCLES - 1);
  assign read_last = (int'(cnt) == rtc_pkg::RD_CYCLES - 1);

  ////////////////////////////////////////////////////////////////////////////
  // phase control and pin drivers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || abort) begin
      phase      <= rtc_pkg::PH_IDLE;
      cnt        <= 2'd0;
      done       <= 1'b0;
      rtc_cs_n   <= 1'b1;
      rtc_ale    <= 1'b0;
      rtc_rd_n   <= 1'b1;
      rtc_ad_out <= 8'h00;
      rtc_ad_oe  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        rtc_pkg::PH_IDLE: begin
          if (rd_req) begin
            phase      <= rtc_pkg::PH_ADDR;
            cnt        <= 2'd0;
            rtc_cs_n   <= 1'b0;
            rtc_ale    <= 1'b1;
            rtc_ad_out <= rd_addr; // address goes out on the shared bus
            rtc_ad_oe  <= 1'b1;
          end
        end
        rtc_pkg::PH_ADDR: begin
          if (addr_last) begin
            phase     <= rtc_pkg::PH_READ;
            cnt       <= 2'd0;
            rtc_ale   <= 1'b0;
            rtc_ad_oe <= 1'b0; // turn the bus around before rd_n falls
            rtc_rd_n  <= 1'b0;
          end else begin
            cnt <= cnt + 2'd1;
          end
        end
        rtc_pkg::PH_READ: begin
          if (read_last) begin
            phase    <= rtc_pkg::PH_IDLE;
            cnt      <= 2'd0;
            done     <= 1'b1;
            rtc_cs_n <= 1'b1;
            rtc_rd_n <= 1'b1;
          end else begin
            cnt <= cnt + 2'd1;
          end
        end
        default: phase <= rtc_pkg::PH_IDLE;
      endcase
    end
  end

  // byte sampled on the last rd_n low cycle, valid with done
  always_ff @(posedge clk) begin
    if (phase == rtc_pkg::PH_READ && read_last) begin
      rd_data <= rtc_ad_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/rtc_read_sequencer.sv */
`default_nettype none

// polling FSM: command read, then the nine time/timer reads, forever
module rtc_read_sequencer (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               start,
  output logic              busy,
  output logic              abort,
  output logic              rd_req,
  output logic        [7:0] rd_addr,
  input  wire               done,
  input  wire         [7:0] rd_data,
  output logic              wr_en,
  output rtc_pkg::reg_idx_t wr_idx,
  output logic        [7:0] wr_data,
  output logic              sweep_end
);

  // state code doubles as register index while a read is open
  rtc_pkg::reg_idx_t st;
  logic              issued;    // rd_req sent for this state
  logic              in_read;
  logic              issue;
  logic              got;
  logic        [7:0] next_addr;

  assign abort   = ~start;
  assign busy    = (st != rtc_pkg::SEQ_IDLE);
  assign in_read = (st != rtc_pkg::SEQ_IDLE) && (st != rtc_pkg::SEQ_FIN);
  assign issue   = in_read && !issued;
  assign got     = in_read && issued && done;

  always_comb begin
    next_addr = rtc_pkg::CMD_ADDR;
    if (st != 4'd0 && int'(st) <= rtc_pkg::NUM_REGS) begin
      next_addr = rtc_pkg::REG_ADDR[st];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || !start) begin // start low throws the sweep away
      st        <= rtc_pkg::SEQ_IDLE;
      issued    <= 1'b0;
      rd_req    <= 1'b0;
      wr_en     <= 1'b0;
      sweep_end <= 1'b0;
    end else begin
      rd_req    <= 1'b0;
      wr_en     <= 1'b0;
      sweep_end <= 1'b0;
      if (st == rtc_pkg::SEQ_IDLE) begin
        st     <= 4'd0;
        issued <= 1'b0;
      end else if (st == rtc_pkg::SEQ_FIN) begin
        sweep_end <= 1'b1;
        st        <= 4'd0; // keep polling
        issued    <= 1'b0;
      end else if (issue) begin
        rd_req <= 1'b1;
        issued <= 1'b1;
      end else if (got) begin
        issued <= 1'b0;
        wr_en  <= (st != 4'd0); // command byte is dropped
        if (int'(st) == rtc_pkg::NUM_REGS) begin
          st <= rtc_pkg::SEQ_FIN;
        end else begin
          st <= st + 4'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address and write payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_addr <= next_addr; // held until done
    end
    if (got) begin
      wr_idx  <= st;
      wr_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/time_regs.sv */
`default_nettype none

// staging store for one sweep, published as a single snapshot
module time_regs (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               abort,
  input  wire               wr_en,
  input  rtc_pkg::reg_idx_t wr_idx,
  input  wire         [7:0] wr_data,
  input  wire               sweep_end,
  output logic        [7:0] sec,
  output logic        [7:0] min,
  output logic        [7:0] hour,
  output logic        [7:0] day,
  output logic        [7:0] month,
  output logic        [7:0] year,
  output logic        [7:0] tmr_sec,
  output logic        [7:0] tmr_min,
  output logic        [7:0] tmr_hour,
  output logic              time_valid
);

  logic [7:0]                 stage [1:rtc_pkg::NUM_REGS];
  logic [1:rtc_pkg::NUM_REGS] mask;    // slots written this sweep
  logic                       slot_ok;
  logic                       publish;

  assign slot_ok = wr_en && (wr_idx != 4'd0) && (int'(wr_idx) <= rtc_pkg::NUM_REGS);
  assign publish = sweep_end && (&mask) && !abort;

  always_ff @(posedge clk) begin
    if (slot_ok) begin
      stage[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || abort) begin
      mask <= '0;
    end else if (sweep_end) begin
      mask <= '0; // next sweep starts empty
    end else if (slot_ok) begin
      mask[wr_idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // published snapshot
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sec        <= 8'h00;
      min        <= 8'h00;
      hour       <= 8'h00;
      day        <= 8'h00;
      month      <= 8'h00;
      year       <= 8'h00;
      tmr_sec    <= 8'h00;
      tmr_min    <= 8'h00;
      tmr_hour   <= 8'h00;
      time_valid <= 1'b0;
    end else begin
      time_valid <= publish;
      if (publish) begin // all nine change together
        sec      <= stage[1];
        min      <= stage[2];
        hour     <= stage[3];
        day      <= stage[4];
        month    <= stage[5];
        year     <= stage[6];
        tmr_sec  <= stage[7];
        tmr_min  <= stage[8];
        tmr_hour <= stage[9];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rtc_reader.sv */
`default_nettype none

module rtc_reader (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        start,
  output logic       busy,
  output logic [7:0] sec,
  output logic [7:0] min,
  output logic [7:0] hour,
  output logic [7:0] day,
  output logic [7:0] month,
  output logic [7:0] year,
  output logic [7:0] tmr_sec,
  output logic [7:0] tmr_min,
  output logic [7:0] tmr_hour,
  output logic       time_valid,
  output logic       rtc_cs_n,
  output logic       rtc_ale,
  output logic       rtc_rd_n,
  output logic [7:0] rtc_ad_out,
  output logic       rtc_ad_oe,
  input  wire  [7:0] rtc_ad_in
);

  logic              abort;
  logic              rd_req;
  logic        [7:0] rd_addr;
  logic        [7:0] rd_data;
  logic              done;
  logic              wr_en;
  rtc_pkg::reg_idx_t wr_idx;
  logic        [7:0] wr_data;
  logic              sweep_end;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer, chip bus, snapshot
  ////////////////////////////////////////////////////////////////////////////

  rtc_read_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .abort     (abort),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .done      (done),
    .rd_data   (rd_data),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .sweep_end (sweep_end)
  );

  rtc_bus_port u_bus (
    .clk        (clk),
    .rst_n      (rst_n),
    .abort      (abort),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .done       (done),
    .rtc_cs_n   (rtc_cs_n),
    .rtc_ale    (rtc_ale),
    .rtc_rd_n   (rtc_rd_n),
    .rtc_ad_out (rtc_ad_out),
    .rtc_ad_oe  (rtc_ad_oe),
    .rtc_ad_in  (rtc_ad_in)
  );

  time_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .abort      (abort),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .sweep_end  (sweep_end),
    .sec        (sec),
    .min        (min),
    .hour       (hour),
    .day        (day),
    .month      (month),
    .year       (year),
    .tmr_sec    (tmr_sec),
    .tmr_min    (tmr_min),
    .tmr_hour   (tmr_hour),
    .time_valid (time_valid)
  );

endmodule

`default_nettype wire

/* sim/rtc_bus_chk.sv */
`default_nettype none

// chip bus protocol rules, bound into rtc_bus_port
module rtc_bus_chk (
  input wire clk,
  input wire rst_n,
  input wire done,
  input wire rtc_cs_n,
  input wire rtc_ale,
  input wire rtc_rd_n,
  input wire rtc_ad_oe
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // strobe rules
  ////////////////////////////////////////////////////////////////////////////

  a_rd_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
    !rtc_rd_n |-> !rtc_cs_n)
    else $error("rd_n low while cs_n is high");

  a_ale_not_rd: assert property (@(posedge clk) disable iff (!rst_n)
    !(rtc_ale && !rtc_rd_n))
    else $error("ale and rd_n asserted in the same cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else $error("done held longer than one cycle");

  // chip owns the bus while rd_n is low
  a_oe_off_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    !rtc_rd_n |-> !rtc_ad_oe)
    else $error("ad_oe high during a read strobe");

endmodule

`default_nettype wire

/* sim/rtc_reader_tb.sv */
`default_nettype none

module rtc_reader_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_SWEEPS       = 5;
  localparam int N_ABORTS       = 4;
  localparam int TIMEOUT_CYCLES = (N_SWEEPS + 2 * N_ABORTS) * 10 * 8 + 400;

  logic       clk;
  logic       rst_n;
  logic       start;
  logic       busy;
  logic [7:0] sec, min, hour, day, month, year, tmr_sec, tmr_min, tmr_hour;
  logic       time_valid;
  logic       rtc_cs_n, rtc_ale, rtc_rd_n, rtc_ad_oe;
  logic [7:0] rtc_ad_out;
  logic [7:0] rtc_ad_in;

  logic [7:0]  chip_mem [0:255];
  logic [7:0]  chip_addr;
  logic        ale_seen;
  logic [7:0]  addr_log [$];   // one entry per ale rise
  logic [7:0]  outs [1:rtc_pkg::NUM_REGS];
  logic [7:0]  snap [1:rtc_pkg::NUM_REGS]; // last published snapshot
  logic [7:0]  cmd_byte;
  logic [31:0] lfsr_state;
  int          cycle_cnt;

  rtc_reader UUT (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
    .sec(sec), .min(min), .hour(hour), .day(day), .month(month), .year(year),
    .tmr_sec(tmr_sec), .tmr_min(tmr_min), .tmr_hour(tmr_hour),
    .time_valid(time_valid),
    .rtc_cs_n(rtc_cs_n), .rtc_ale(rtc_ale), .rtc_rd_n(rtc_rd_n),
    .rtc_ad_out(rtc_ad_out), .rtc_ad_oe(rtc_ad_oe), .rtc_ad_in(rtc_ad_in)
  );

  bind rtc_bus_port rtc_bus_chk u_bus_chk (
    .clk(clk), .rst_n(rst_n), .done(done), .rtc_cs_n(rtc_cs_n),
    .rtc_ale(rtc_ale), .rtc_rd_n(rtc_rd_n), .rtc_ad_oe(rtc_ad_oe)
  );

  assign outs[1] = sec;
  assign outs[2] = min;
  assign outs[3] = hour;
  assign outs[4] = day;
  assign outs[5] = month;
  assign outs[6] = year;
  assign outs[7] = tmr_sec;
  assign outs[8] = tmr_min;
  assign outs[9] = tmr_hour;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // chip model: address latch and read data
  ////////////////////////////////////////////////////////////////////////////

  assign rtc_ad_in = (rtc_rd_n === 1'b0) ? chip_mem[chip_addr] : 8'h00;

  always @(negedge clk) begin
    if (rtc_ale === 1'b1) begin
      chip_addr = rtc_ad_out;
      if (!ale_seen) addr_log.push_back(rtc_ad_out);
    end
    ale_seen = (rtc_ale === 1'b1);
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: no end of test after %0d cycles", cycle_cnt);
      stop_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int k;
    val = '0;
    for (k = 0; k < n; k++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic string reg_name(input int i);
    case (i)
      1: return "sec";
      2: return "min";
      3: return "hour";
      4: return "day";
      5: return "month";
      6: return "year";
      7: return "tmr_sec";
      8: return "tmr_min";
      default: return "tmr_hour";
    endcase
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_idx(input rtc_pkg::reg_idx_t slot, input logic [7:0] got,
                           input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: rtc_ad_out of slot %0d got %h expected %h",
               $time, slot, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic byte_in_table(input logic [7:0] b);
    for (int i = 1; i <= rtc_pkg::NUM_REGS; i++) begin
      if (chip_mem[rtc_pkg::REG_ADDR[i]] == b) return 1'b1;
    end
    return 1'b0;
  endfunction

  // new table bytes, command byte kept apart from all of them
  task automatic randomize_chip();
    logic [31:0] v;
    for (int i = 1; i <= rtc_pkg::NUM_REGS; i++) begin
      take_bits(8, v);
      chip_mem[rtc_pkg::REG_ADDR[i]] = v[7:0];
    end
    take_bits(8, v);
    cmd_byte = v[7:0];
    while (byte_in_table(cmd_byte)) cmd_byte = cmd_byte + 8'd1;
    chip_mem[rtc_pkg::CMD_ADDR] = cmd_byte;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // cycle helpers, sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(negedge clk);
    if (rtc_ale) begin // address phase drives the bus
      check_bit("rtc_cs_n", rtc_cs_n, 1'b0);
      check_bit("rtc_ad_oe", rtc_ad_oe, 1'b1);
    end
    if (!rtc_rd_n) begin
      check_bit("rtc_cs_n", rtc_cs_n, 1'b0);
      check_bit("rtc_ale", rtc_ale, 1'b0);
      check_bit("rtc_ad_oe", rtc_ad_oe, 1'b0);
    end
  endtask

  task automatic check_held();
    for (int i = 1; i <= rtc_pkg::NUM_REGS; i++) check_byte(reg_name(i), outs[i], snap[i]);
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) begin
      step_cycle();
      check_bit("time_valid", time_valid, 1'b0);
      check_held();
    end
  endtask

  task automatic wait_publish();
    step_cycle();
    while (!time_valid) begin
      check_held(); // staging writes must not leak out
      step_cycle();
    end
    check_bit("busy", busy, 1'b1); // polling goes on after the pulse
  endtask

  task automatic check_sweep();
    if (addr_log.size() != rtc_pkg::NUM_REGS + 1) begin
      $display("sweep logged %0d chip addresses instead of %0d",
               addr_log.size(), rtc_pkg::NUM_REGS + 1);
      stop_run();
    end
    check_idx(4'd0, addr_log[0], rtc_pkg::CMD_ADDR);
    for (int i = 1; i <= rtc_pkg::NUM_REGS; i++) begin
      check_idx(rtc_pkg::reg_idx_t'(i), addr_log[i], rtc_pkg::REG_ADDR[i]);
      check_byte(reg_name(i), outs[i], chip_mem[rtc_pkg::REG_ADDR[i]]);
      snap[i] = outs[i];
    end
    addr_log.delete();
  endtask

  task automatic check_bus_idle();
    check_bit("rtc_cs_n", rtc_cs_n, 1'b1);
    check_bit("rtc_ale", rtc_ale, 1'b0);
    check_bit("rtc_rd_n", rtc_rd_n, 1'b1);
    check_bit("rtc_ad_oe", rtc_ad_oe, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("time_valid", time_valid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    rst_n      = 1'b0;
    start      = 1'b0;
    cycle_cnt  = 0;
    ale_seen   = 1'b0;
    chip_addr  = 8'h00;
    lfsr_state = 32'h1aad;
    for (int a = 0; a < 256; a++) begin
      take_bits(8, v);
      chip_mem[a] = v[7:0];
    end
    for (int i = 1; i <= rtc_pkg::NUM_REGS; i++) snap[i] = 8'h00;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    step_cycle();
    step_cycle();
    check_bus_idle(); // start still low
    check_held();

    randomize_chip();
    @(posedge clk);
    start <= 1'b1;
    for (int s = 0; s < N_SWEEPS; s++) begin
      wait_publish();
      check_sweep();
      randomize_chip();
    end

    // drop start somewhere inside the next sweep
    for (int n = 0; n < N_ABORTS; n++) begin
      take_bits(6, v);
      hold_cycles(1 + int'(v[5:0]));
      @(posedge clk);
      start <= 1'b0;
      hold_cycles(3);
      check_bus_idle();
      addr_log.delete();
      randomize_chip();
      @(posedge clk);
      start <= 1'b1;
      wait_publish();
      check_sweep();
      randomize_chip();
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* rtc_reader.f */
verilog/rtc_pkg.sv
verilog/rtc_bus_port.sv
verilog/rtc_read_sequencer.sv
verilog/time_regs.sv
verilog/rtc_reader.sv
sim/rtc_bus_chk.sv
sim/rtc_reader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rtc_reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module rtc_reader_tb \
  -f rtc_reader.f -o rtc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rtc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
